//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef enum logic [3:0] {
        NOP   = 4'd0,
        LD    = 4'd1,
        LDR   = 4'd2,
        LDI   = 4'd3,
        ST    = 4'd4,
        STR   = 4'd5,
        PUSH  = 4'd6,
        POP   = 4'd7,
        ALU_R = 4'd8,
        ALU_I = 4'd9,
        INT   = 4'd10,
        HALT  = 4'd11
    } opcode_e;

    // codes 11 to 15 behave as always
    typedef enum logic [3:0] {
        ALWAYS = 4'd0,
        EQ     = 4'd1,
        NE     = 4'd2,
        LTU    = 4'd3,
        GTU    = 4'd4,
        LEU    = 4'd5,
        GEU    = 4'd6,
        LTS    = 4'd7,
        GTS    = 4'd8,
        LES    = 4'd9,
        GES    = 4'd10
    } cond_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SHL  = 4'd5,
        SHR  = 4'd6,
        PASS = 4'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        HALTED,
        FETCH,
        EXEC,
        TRAP_PUSH,
        TRAP_JUMP
    } state_e;

    typedef enum logic [2:0] {
        R0 = 3'd0,
        R1 = 3'd1,
        R2 = 3'd2,
        R3 = 3'd3,
        R4 = 3'd4,
        R5 = 3'd5,
        SP = 3'd6,
        PC = 3'd7
    } reg_e;

    // instruction fields
    localparam int OP_HI = 31;
    localparam int OP_LO = 28;
    localparam int COND_HI = 27;
    localparam int COND_LO = 24;
    localparam int RA_HI = 23;
    localparam int RA_LO = 21;
    localparam int RB_HI = 20;
    localparam int RB_LO = 18;
    localparam int ALUOP_HI = 17;
    localparam int ALUOP_LO = 14;
    localparam int SET_FLAGS_BIT = 13;
    localparam int NO_WRITE_BIT = 12;
    localparam int RC_HI = 11;
    localparam int RC_LO = 9;
    localparam int OFF_HI = 8;
    localparam int OFF_LO = 0;
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;
    localparam int DADDR_HI = 7;
    localparam int DADDR_LO = 0;

    // flag vector is {z, c, n, v}
    localparam int FLAG_Z = 3;
    localparam int FLAG_C = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_V = 0;

    localparam int MEM_WORDS = 256;
    localparam logic [31:0] VEC_SWINT = 32'd2;
    localparam logic [31:0] VEC_EXCEPT = 32'd3;
    localparam logic [31:0] SP_RESET = 32'h0000_00f0;

    localparam logic [10:0] CTRL_ADDR = 11'h400;
    localparam logic [10:0] STATUS_ADDR = 11'h404;

endpackage

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
    input  logic             rst,
    input  logic             reset,
    input  cpu_pkg::alu_op_e alu_op,
    input  logic [31:0]      a_data,
    input  logic [31:0]      b_data,
    input  logic [31:0]      imm,
    input  logic             a_from_ir,
    input  logic             b_from_ir,
    input  logic             ld_flags,
    output logic [31:0]      result,
    output logic [3:0]       flags
);

    logic [31:0] a_op;
    logic [31:0] b_op;
    logic [32:0] sum;
    logic c_out;
    logic v_out;

    assign a_op = a_from_ir ? imm : a_data;
    assign b_op = b_from_ir ? imm : b_data;

    always_comb begin
        sum = 33'd0;
        c_out = 1'b0;
        v_out = 1'b0;
        case (alu_op)
            cpu_pkg::ADD: begin
                sum = {1'b0, a_op} + {1'b0, b_op};
                c_out = sum[32];
                v_out = (a_op[31] == b_op[31]) && (sum[31] != a_op[31]);
            end
            // carry out here is the inverted borrow
            cpu_pkg::SUB: begin
                sum = {1'b0, a_op} + {1'b0, ~b_op} + 33'd1;
                c_out = sum[32];
                v_out = (a_op[31] != b_op[31]) && (sum[31] != a_op[31]);
            end
            default: ;
        endcase
        case (alu_op)
            cpu_pkg::ADD, cpu_pkg::SUB: result = sum[31:0];
            cpu_pkg::AND: result = a_op & b_op;
            cpu_pkg::OR:  result = a_op | b_op;
            cpu_pkg::XOR: result = a_op ^ b_op;
            cpu_pkg::SHL: result = a_op << b_op[4:0];
            cpu_pkg::SHR: result = a_op >> b_op[4:0];
            default:      result = b_op;
        endcase
    end

    always_ff @(posedge rst) begin
        if (reset) begin
            flags <= 4'd0;
        end else if (ld_flags) begin
            flags[cpu_pkg::FLAG_Z] <= result == 32'd0;
            flags[cpu_pkg::FLAG_C] <= c_out;
            flags[cpu_pkg::FLAG_N] <= result[31];
            flags[cpu_pkg::FLAG_V] <= v_out;
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none

module reg_file (
    input  logic          rst,
    input  logic          reset,
    input  cpu_pkg::reg_e sel_a,
    input  cpu_pkg::reg_e sel_b,
    input  cpu_pkg::reg_e sel_in,
    input  logic          ld_reg,
    input  logic [31:0]   wdata,
    input  logic          post_inc_pc,
    input  logic          pre_dec_sp,
    input  logic          post_inc_sp,
    output logic [31:0]   a_data,
    output logic [31:0]   b_data,
    output logic [7:0]    pc
);

    logic [31:0] regs [8];

    assign a_data = regs[sel_a];
    // push address is the decremented sp
    assign b_data = (pre_dec_sp && sel_b == cpu_pkg::SP) ? regs[cpu_pkg::SP] - 32'd1
                                                          : regs[sel_b];
    assign pc = regs[cpu_pkg::PC][7:0];

    always_ff @(posedge rst) begin
        if (reset) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= 32'd0;
            regs[cpu_pkg::SP] <= cpu_pkg::SP_RESET;
        end else begin
            if (post_inc_pc)
                regs[cpu_pkg::PC] <= regs[cpu_pkg::PC] + 32'd1;
            if (pre_dec_sp)
                regs[cpu_pkg::SP] <= regs[cpu_pkg::SP] - 32'd1;
            if (post_inc_sp)
                regs[cpu_pkg::SP] <= regs[cpu_pkg::SP] + 32'd1;
            // explicit load wins over the pointer updates
            if (ld_reg)
                regs[sel_in] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`default_nettype none

module control_unit (
    input  logic             rst,
    input  logic             reset,
    input  logic             start,
    input  logic [31:0]      mem_rdata,
    input  logic [3:0]       flags,
    input  logic [31:0]      a_data,
    output logic             halted,
    output logic             mem_rd,
    output logic             mem_wr,
    output logic             addr_sel,
    output logic             src_mem,
    output cpu_pkg::reg_e    sel_a,
    output cpu_pkg::reg_e    sel_b,
    output cpu_pkg::reg_e    sel_in,
    output logic             ld_reg,
    output logic             post_inc_pc,
    output logic             pre_dec_sp,
    output logic             post_inc_sp,
    output cpu_pkg::alu_op_e alu_op,
    output logic             a_from_ir,
    output logic             b_from_ir,
    output logic [31:0]      imm,
    output logic             ld_flags,
    output logic [31:0]      mem_wdata
);

    cpu_pkg::state_e state;
    cpu_pkg::state_e state_next;
    logic [31:0] ir;
    cpu_pkg::opcode_e fetch_op;
    cpu_pkg::opcode_e op;
    cpu_pkg::reg_e ra;
    cpu_pkg::reg_e rb;
    cpu_pkg::reg_e rc;
    logic cond_ok;

    // carry set means no borrow for the unsigned tests
    function automatic logic cond_pass(input cpu_pkg::cond_e cond, input logic [3:0] f);
        logic z;
        logic c;
        logic n;
        logic v;
        z = f[cpu_pkg::FLAG_Z];
        c = f[cpu_pkg::FLAG_C];
        n = f[cpu_pkg::FLAG_N];
        v = f[cpu_pkg::FLAG_V];
        case (cond)
            cpu_pkg::EQ:  cond_pass = z;
            cpu_pkg::NE:  cond_pass = !z;
            cpu_pkg::LTU: cond_pass = !c;
            cpu_pkg::GTU: cond_pass = c && !z;
            cpu_pkg::LEU: cond_pass = !c || z;
            cpu_pkg::GEU: cond_pass = c;
            cpu_pkg::LTS: cond_pass = n != v;
            cpu_pkg::GTS: cond_pass = !z && (n == v);
            cpu_pkg::LES: cond_pass = z || (n != v);
            cpu_pkg::GES: cond_pass = n == v;
            default:      cond_pass = 1'b1;
        endcase
    endfunction

    // decode of the word on the bus during fetch
    assign fetch_op = cpu_pkg::opcode_e'(mem_rdata[cpu_pkg::OP_HI:cpu_pkg::OP_LO]);
    assign cond_ok = cond_pass(cpu_pkg::cond_e'(mem_rdata[cpu_pkg::COND_HI:cpu_pkg::COND_LO]),
                               flags);

    assign op = cpu_pkg::opcode_e'(ir[cpu_pkg::OP_HI:cpu_pkg::OP_LO]);
    assign ra = cpu_pkg::reg_e'(ir[cpu_pkg::RA_HI:cpu_pkg::RA_LO]);
    assign rb = cpu_pkg::reg_e'(ir[cpu_pkg::RB_HI:cpu_pkg::RB_LO]);
    assign rc = cpu_pkg::reg_e'(ir[cpu_pkg::RC_HI:cpu_pkg::RC_LO]);

    assign halted = state == cpu_pkg::HALTED;
    assign mem_wdata = a_data;

    always_comb begin
        state_next = state;
        case (state)
            cpu_pkg::HALTED: begin
                if (start)
                    state_next = cpu_pkg::FETCH;
            end
            cpu_pkg::FETCH: begin
                if (cond_ok) begin
                    case (fetch_op)
                        cpu_pkg::NOP, cpu_pkg::LD, cpu_pkg::LDR, cpu_pkg::LDI,
                        cpu_pkg::ST, cpu_pkg::STR, cpu_pkg::PUSH, cpu_pkg::POP,
                        cpu_pkg::ALU_R, cpu_pkg::ALU_I, cpu_pkg::HALT:
                            state_next = cpu_pkg::EXEC;
                        // software interrupt and undefined opcodes
                        default:
                            state_next = cpu_pkg::TRAP_PUSH;
                    endcase
                end
            end
            cpu_pkg::EXEC: begin
                state_next = (op == cpu_pkg::HALT) ? cpu_pkg::HALTED : cpu_pkg::FETCH;
            end
            cpu_pkg::TRAP_PUSH: state_next = cpu_pkg::TRAP_JUMP;
            default: state_next = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge rst) begin
        if (reset)
            state <= cpu_pkg::HALTED;
        else
            state <= state_next;
    end

    always_ff @(posedge rst) begin
        if (state == cpu_pkg::FETCH)
            ir <= mem_rdata;
    end

    always_comb begin
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        addr_sel = 1'b0;
        src_mem = 1'b0;
        sel_a = cpu_pkg::R0;
        sel_b = cpu_pkg::R0;
        sel_in = ra;
        ld_reg = 1'b0;
        post_inc_pc = 1'b0;
        pre_dec_sp = 1'b0;
        post_inc_sp = 1'b0;
        alu_op = cpu_pkg::PASS;
        a_from_ir = 1'b0;
        b_from_ir = 1'b0;
        ld_flags = 1'b0;
        imm = {{20{ir[cpu_pkg::IMM_HI]}}, ir[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};
        case (state)
            // ir <- mem[pc++]
            cpu_pkg::FETCH: begin
                sel_b = cpu_pkg::PC;
                mem_rd = 1'b1;
                post_inc_pc = 1'b1;
            end
            cpu_pkg::EXEC: begin
                case (op)
                    cpu_pkg::LD, cpu_pkg::ST: begin
                        imm = {24'd0, ir[cpu_pkg::DADDR_HI:cpu_pkg::DADDR_LO]};
                        addr_sel = 1'b1;
                        sel_a = ra;
                        mem_rd = op == cpu_pkg::LD;
                        mem_wr = op == cpu_pkg::ST;
                        src_mem = 1'b1;
                        ld_reg = op == cpu_pkg::LD;
                    end
                    // address is offset plus rb
                    cpu_pkg::LDR, cpu_pkg::STR: begin
                        imm = {{23{ir[cpu_pkg::OFF_HI]}}, ir[cpu_pkg::OFF_HI:cpu_pkg::OFF_LO]};
                        a_from_ir = 1'b1;
                        sel_a = ra;
                        sel_b = rb;
                        alu_op = cpu_pkg::ADD;
                        mem_rd = op == cpu_pkg::LDR;
                        mem_wr = op == cpu_pkg::STR;
                        src_mem = 1'b1;
                        ld_reg = op == cpu_pkg::LDR;
                    end
                    cpu_pkg::LDI: begin
                        b_from_ir = 1'b1;
                        ld_reg = 1'b1;
                    end
                    // mem[--sp] <- ra
                    cpu_pkg::PUSH: begin
                        sel_a = ra;
                        sel_b = cpu_pkg::SP;
                        pre_dec_sp = 1'b1;
                        mem_wr = 1'b1;
                    end
                    // ra <- mem[sp++]
                    cpu_pkg::POP: begin
                        sel_b = cpu_pkg::SP;
                        mem_rd = 1'b1;
                        src_mem = 1'b1;
                        ld_reg = 1'b1;
                        post_inc_sp = 1'b1;
                    end
                    cpu_pkg::ALU_R, cpu_pkg::ALU_I: begin
                        sel_a = rb;
                        sel_b = rc;
                        b_from_ir = op == cpu_pkg::ALU_I;
                        alu_op = cpu_pkg::alu_op_e'(ir[cpu_pkg::ALUOP_HI:cpu_pkg::ALUOP_LO]);
                        ld_flags = ir[cpu_pkg::SET_FLAGS_BIT];
                        ld_reg = !ir[cpu_pkg::NO_WRITE_BIT];
                    end
                    default: ;
                endcase
            end
            // return pc goes to mem[--sp]
            cpu_pkg::TRAP_PUSH: begin
                sel_a = cpu_pkg::PC;
                sel_b = cpu_pkg::SP;
                pre_dec_sp = 1'b1;
                mem_wr = 1'b1;
            end
            cpu_pkg::TRAP_JUMP: begin
                imm = (op == cpu_pkg::INT) ? cpu_pkg::VEC_SWINT : cpu_pkg::VEC_EXCEPT;
                b_from_ir = 1'b1;
                sel_in = cpu_pkg::PC;
                ld_reg = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/shared_memory.sv
`default_nettype none

module shared_memory (
    input  logic        rst,
    input  logic        reset,
    input  logic        halted,
    input  logic [7:0]  pc,
    input  logic [7:0]  mem_addr,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic [31:0] mem_wdata,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [10:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] mem_rdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        start
);

    logic [31:0] mem [cpu_pkg::MEM_WORDS];
    logic is_mem;
    logic [7:0] host_addr;
    logic host_done;

    assign is_mem = !paddr[10];
    assign host_addr = paddr[9:2];
    // memory window waits while the core runs
    assign pready = is_mem ? halted : 1'b1;
    assign host_done = psel && penable && pready;

    assign mem_rdata = mem_rd ? mem[mem_addr] : 32'd0;

    always_comb begin
        if (paddr == cpu_pkg::STATUS_ADDR)
            prdata = {16'd0, pc, 7'd0, halted};
        else if (is_mem)
            prdata = mem[host_addr];
        else
            prdata = 32'd0;
    end

    always_ff @(posedge rst) begin
        if (mem_wr)
            mem[mem_addr] <= mem_wdata;
        else if (host_done && pwrite && is_mem)
            mem[host_addr] <= pwdata;
    end

    always_ff @(posedge rst) begin
        if (reset)
            start <= 1'b0;
        else
            start <= host_done && pwrite && paddr == cpu_pkg::CTRL_ADDR && pwdata[0] && halted;
    end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`default_nettype none

module cpu_top (
    input  logic        rst,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [10:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        halted
);

    logic start;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
    logic [7:0] mem_addr;
    logic mem_rd;
    logic mem_wr;
    logic addr_sel;
    logic src_mem;
    cpu_pkg::reg_e sel_a;
    cpu_pkg::reg_e sel_b;
    cpu_pkg::reg_e sel_in;
    logic ld_reg;
    logic post_inc_pc;
    logic pre_dec_sp;
    logic post_inc_sp;
    cpu_pkg::alu_op_e alu_op;
    logic a_from_ir;
    logic b_from_ir;
    logic [31:0] imm;
    logic ld_flags;
    logic [3:0] flags;
    logic [31:0] a_data;
    logic [31:0] b_data;
    logic [31:0] result;
    logic [31:0] wdata;
    logic [7:0] pc;

    // direct address rides in the low immediate byte
    assign mem_addr = addr_sel ? imm[7:0] : result[7:0];
    assign wdata = src_mem ? mem_rdata : result;

    control_unit control_unit_i (
        .rst         (rst),
        .reset       (reset),
        .start       (start),
        .mem_rdata   (mem_rdata),
        .flags       (flags),
        .a_data      (a_data),
        .halted      (halted),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .addr_sel    (addr_sel),
        .src_mem     (src_mem),
        .sel_a       (sel_a),
        .sel_b       (sel_b),
        .sel_in      (sel_in),
        .ld_reg      (ld_reg),
        .post_inc_pc (post_inc_pc),
        .pre_dec_sp  (pre_dec_sp),
        .post_inc_sp (post_inc_sp),
        .alu_op      (alu_op),
        .a_from_ir   (a_from_ir),
        .b_from_ir   (b_from_ir),
        .imm         (imm),
        .ld_flags    (ld_flags),
        .mem_wdata   (mem_wdata)
    );

    alu alu_i (
        .rst       (rst),
        .reset     (reset),
        .alu_op    (alu_op),
        .a_data    (a_data),
        .b_data    (b_data),
        .imm       (imm),
        .a_from_ir (a_from_ir),
        .b_from_ir (b_from_ir),
        .ld_flags  (ld_flags),
        .result    (result),
        .flags     (flags)
    );

    reg_file reg_file_i (
        .rst         (rst),
        .reset       (reset),
        .sel_a       (sel_a),
        .sel_b       (sel_b),
        .sel_in      (sel_in),
        .ld_reg      (ld_reg),
        .wdata       (wdata),
        .post_inc_pc (post_inc_pc),
        .pre_dec_sp  (pre_dec_sp),
        .post_inc_sp (post_inc_sp),
        .a_data      (a_data),
        .b_data      (b_data),
        .pc          (pc)
    );

    shared_memory shared_memory_i (
        .rst       (rst),
        .reset     (reset),
        .halted    (halted),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .mem_rdata (mem_rdata),
        .prdata    (prdata),
        .pready    (pready),
        .start     (start)
    );

endmodule

`default_nettype wire

//--- bench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-set model state
logic [31:0] model_mem [256];
logic [31:0] model_reg [8];
// {z, c, n, v}
logic [3:0] model_flags;

function automatic logic model_cond(input logic [3:0] cond, input logic [3:0] f);
    logic eq;
    logic lt_u;
    logic lt_s;
    eq = f[3];
    // carry set is no borrow
    lt_u = !f[2];
    lt_s = f[1] ^ f[0];
    case (cond)
        cpu_pkg::EQ:  return eq;
        cpu_pkg::NE:  return !eq;
        cpu_pkg::LTU: return lt_u;
        cpu_pkg::GTU: return !lt_u && !eq;
        cpu_pkg::LEU: return lt_u || eq;
        cpu_pkg::GEU: return !lt_u;
        cpu_pkg::LTS: return lt_s;
        cpu_pkg::GTS: return !lt_s && !eq;
        cpu_pkg::LES: return lt_s || eq;
        cpu_pkg::GES: return !lt_s;
        default:      return 1'b1;
    endcase
endfunction

function automatic logic [31:0] model_alu(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b, output logic [3:0] f);
    logic [32:0] wide;
    logic [31:0] res;
    logic c;
    logic v;
    c = 1'b0;
    v = 1'b0;
    case (op)
        cpu_pkg::ADD: begin
            wide = {1'b0, a} + {1'b0, b};
            res = wide[31:0];
            c = wide[32];
            v = (a[31] == b[31]) && (res[31] != a[31]);
        end
        cpu_pkg::SUB: begin
            res = a - b;
            c = a >= b;
            v = (a[31] != b[31]) && (res[31] != a[31]);
        end
        cpu_pkg::AND: res = a & b;
        cpu_pkg::OR:  res = a | b;
        cpu_pkg::XOR: res = a ^ b;
        cpu_pkg::SHL: res = a << b[4:0];
        cpu_pkg::SHR: res = a >> b[4:0];
        default:      res = b;
    endcase
    f = {res == 32'd0, c, res[31], v};
    return res;
endfunction

task automatic model_reset();
    for (int i = 0; i < 8; i++)
        model_reg[i] = 32'd0;
    model_reg[6] = cpu_pkg::SP_RESET;
    model_flags = 4'd0;
endtask

task automatic model_run(output logic ok);
    logic [31:0] w;
    logic [3:0] op;
    logic [2:0] ra;
    logic [2:0] rb;
    logic [31:0] simm;
    logic [31:0] soff;
    logic [31:0] bval;
    logic [31:0] res;
    logic [3:0] f;
    logic [7:0] addr;
    logic done;
    int steps;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 2000) begin
        w = model_mem[model_reg[7][7:0]];
        model_reg[7] = model_reg[7] + 32'd1;
        steps++;
        op = w[31:28];
        ra = w[23:21];
        rb = w[20:18];
        simm = {{20{w[11]}}, w[11:0]};
        soff = {{23{w[8]}}, w[8:0]};
        if (model_cond(w[27:24], model_flags)) begin
            case (op)
                cpu_pkg::NOP: ;
                cpu_pkg::LD:  model_reg[ra] = model_mem[w[7:0]];
                cpu_pkg::ST:  model_mem[w[7:0]] = model_reg[ra];
                cpu_pkg::LDR, cpu_pkg::STR: begin
                    addr = 8'(soff + model_reg[rb]);
                    if (op == cpu_pkg::LDR)
                        model_reg[ra] = model_mem[addr];
                    else
                        model_mem[addr] = model_reg[ra];
                end
                cpu_pkg::LDI: model_reg[ra] = simm;
                cpu_pkg::PUSH: begin
                    model_reg[6] = model_reg[6] - 32'd1;
                    model_mem[model_reg[6][7:0]] = model_reg[ra];
                end
                cpu_pkg::POP: begin
                    res = model_mem[model_reg[6][7:0]];
                    model_reg[6] = model_reg[6] + 32'd1;
                    model_reg[ra] = res;
                end
                cpu_pkg::ALU_R, cpu_pkg::ALU_I: begin
                    bval = (op == cpu_pkg::ALU_I) ? simm : model_reg[w[11:9]];
                    res = model_alu(w[17:14], model_reg[rb], bval, f);
                    if (w[13])
                        model_flags = f;
                    if (!w[12])
                        model_reg[ra] = res;
                end
                cpu_pkg::HALT: done = 1'b1;
                // software interrupt and every undefined code
                default: begin
                    model_reg[6] = model_reg[6] - 32'd1;
                    model_mem[model_reg[6][7:0]] = model_reg[7];
                    model_reg[7] = (op == cpu_pkg::INT) ? cpu_pkg::VEC_SWINT
                                                        : cpu_pkg::VEC_EXCEPT;
                end
            endcase
        end
    end
    ok = done;
endtask

`endif

//--- bench/cpu_tb.sv
`default_nettype none

module cpu_tb;

    localparam int NUM_RANDOM = 6;
    localparam int NUM_TESTS = NUM_RANDOM + 2;
    localparam int MAX_LEN = 128;
    // program run plus image load, readback and reset
    localparam int TEST_CYCLES = MAX_LEN * 3 + 1024;
    localparam int WATCHDOG_TIME = NUM_TESTS * TEST_CYCLES * 10 + 2000;

    logic rst;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [10:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic halted;

    int seed = 82488;
    int errors = 0;
    int checks = 0;
    logic [31:0] prog [MAX_LEN];
    int prog_len;
    logic [31:0] dut_mem [256];

    `include "cpu_model.svh"

    cpu_top dut_i (
        .rst     (rst),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .halted  (halted)
    );

    always #5 rst = ~rst;

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [31:0] enc(input logic [3:0] op, input logic [3:0] cond,
                                        input logic [2:0] ra, input logic [2:0] rb,
                                        input logic [3:0] aop, input logic sf,
                                        input logic nw, input logic [11:0] low);
        return {op, cond, ra, rb, aop, sf, nw, low};
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'h80};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input logic got_halted, input logic pin_halted,
                                input logic [7:0] got_pc, input logic [7:0] exp_pc);
        checks++;
        if (got_halted !== 1'b1 || pin_halted !== 1'b1 || got_pc !== exp_pc) begin
            errors++;
            $display("[FAIL] t=%0t status: halted %b pin %b pc %h expected halted 1 pc %h",
                     $time, got_halted, pin_halted, got_pc, exp_pc);
        end
    endtask

    task automatic check_apb_wait(input int waits);
        checks++;
        if (waits == 0) begin
            errors++;
            $display("[FAIL] t=%0t memory read while running completed with no wait",
                     $time);
        end
    endtask

    // one transfer entered and left just after a rising edge
    task automatic apb_xfer(input logic wr, input logic [10:0] addr, input logic [31:0] wd,
                            output logic [31:0] rd, output int waits);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wd;
        @(posedge rst);
        #1;
        penable = 1'b1;
        waits = 0;
        @(negedge rst);
        while (!pready) begin
            waits++;
            @(negedge rst);
        end
        rd = prdata;
        @(posedge rst);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic do_reset();
        reset = 1'b1;
        repeat (16) @(posedge rst);
        #1;
        reset = 1'b0;
    endtask

    task automatic gen_random_program();
        int depth;
        int kind;
        logic [3:0] cond;
        logic [2:0] ra;
        logic [3:0] op;
        logic [8:0] off;
        prog_len = 0;
        depth = 0;
        for (int i = 0; i < 5; i++)
            emit(enc(cpu_pkg::LDI, 4'd0, 3'(i), 3'd0, 4'd0, 1'b0, 1'b0, 12'(rand_below(4096))));
        for (int k = 0; k < 30; k++) begin
            kind = rand_below(8);
            cond = (rand_below(3) == 0) ? 4'(rand_below(16)) : 4'd0;
            ra = 3'(rand_below(5));
            case (kind)
                0: emit(enc(cpu_pkg::LDI, cond, ra, 3'd0, 4'd0, 1'b0, 1'b0,
                            12'(rand_below(4096))));
                1, 2: emit(enc(cpu_pkg::ALU_R, cond, ra, 3'(rand_below(6)),
                               4'(rand_below(8)), 1'(rand_below(2)), rand_below(4) == 0,
                               {3'(rand_below(6)), 9'd0}));
                3: emit(enc(cpu_pkg::ALU_I, cond, ra, 3'(rand_below(6)), 4'(rand_below(8)),
                            1'(rand_below(2)), rand_below(4) == 0, 12'(rand_below(4096))));
                4: begin
                    op = rand_below(2) ? cpu_pkg::LD : cpu_pkg::ST;
                    emit(enc(op, cond, ra, 3'd0, 4'd0, 1'b0, 1'b0,
                             {4'd0, 8'(8'h80 + rand_below(8'h58))}));
                end
                5: begin
                    // base a0..bf, offset -32..31 keeps the window
                    emit(enc(cpu_pkg::LDI, 4'd0, 3'd5, 3'd0, 4'd0, 1'b0, 1'b0,
                             12'(12'h0a0 + rand_below(32))));
                    op = rand_below(2) ? cpu_pkg::LDR : cpu_pkg::STR;
                    off = 9'(rand_below(64) - 32);
                    emit(enc(op, cond, ra, 3'd5, 4'd0, 1'b0, 1'b0, {3'd0, off}));
                end
                6: begin
                    if (depth < 6) begin
                        emit(enc(cpu_pkg::PUSH, 4'd0, ra, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
                        depth++;
                    end else begin
                        emit(enc(cpu_pkg::NOP, cond, 3'd0, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
                    end
                end
                default: begin
                    if (depth > 0) begin
                        emit(enc(cpu_pkg::POP, 4'd0, ra, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
                        depth--;
                    end else begin
                        emit(enc(cpu_pkg::NOP, cond, 3'd0, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
                    end
                end
            endcase
        end
        // sp copied out through r5, then the registers
        emit(enc(cpu_pkg::ALU_I, 4'd0, 3'd5, 3'd6, cpu_pkg::OR, 1'b0, 1'b0, 12'd0));
        emit(enc(cpu_pkg::ST, 4'd0, 3'd5, 3'd0, 4'd0, 1'b0, 1'b0, 12'h0de));
        for (int i = 0; i < 5; i++)
            emit(enc(cpu_pkg::ST, 4'd0, 3'(i), 3'd0, 4'd0, 1'b0, 1'b0, 12'(12'h0d8 + i)));
        emit(enc(cpu_pkg::HALT, 4'd0, 3'd0, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
    endtask

    task automatic build_trap_program(input logic illegal, input logic [11:0] marker);
        prog_len = 0;
        emit(enc(cpu_pkg::LDI, 4'd0, 3'd4, 3'd0, 4'd0, 1'b0, 1'b0, marker));
        if (illegal)
            emit(32'hc000_0000);
        else
            emit(enc(cpu_pkg::INT, 4'd0, 3'd0, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
        // word 2 only runs as the interrupt handler
        if (illegal)
            emit(enc(cpu_pkg::ST, 4'd0, 3'd4, 3'd0, 4'd0, 1'b0, 1'b0, 12'h0d1));
        emit(enc(cpu_pkg::ST, 4'd0, 3'd4, 3'd0, 4'd0, 1'b0, 1'b0, 12'h0d0));
        emit(enc(cpu_pkg::HALT, 4'd0, 3'd0, 3'd0, 4'd0, 1'b0, 1'b0, 12'd0));
    endtask

    task automatic run_test(input logic [7:0] probe);
        logic [31:0] img;
        logic [31:0] rd;
        logic ok;
        int waits;
        int polls;
        do_reset();
        for (int a = 0; a < 256; a++) begin
            img = (a < prog_len) ? prog[a] : fill_word(8'(a));
            model_mem[a] = img;
            apb_xfer(1'b1, {1'b0, 8'(a), 2'b00}, img, rd, waits);
        end
        model_reset();
        model_run(ok);
        if (!ok) begin
            errors++;
            $display("model did not reach HALT within its step limit");
        end
        apb_xfer(1'b1, cpu_pkg::CTRL_ADDR, 32'd1, rd, waits);
        apb_xfer(1'b0, {1'b0, probe, 2'b00}, 32'd0, rd, waits);
        check_apb_wait(waits);
        check_word(rd, model_mem[probe], "read during run");
        rd = 32'd0;
        polls = 0;
        while (!rd[0] && polls < 4) begin
            apb_xfer(1'b0, cpu_pkg::STATUS_ADDR, 32'd0, rd, waits);
            polls++;
        end
        check_status(rd[0], halted, rd[15:8], model_reg[7][7:0]);
        for (int a = 8'h80; a < 256; a++) begin
            apb_xfer(1'b0, {1'b0, 8'(a), 2'b00}, 32'd0, rd, waits);
            dut_mem[a] = rd;
            check_word(rd, model_mem[a], $sformatf("mem[%h]", a));
        end
    endtask

    task automatic report_test(input int t, input string name, input int err_before);
        if (errors == err_before)
            $display("test %0d %s: ok", t, name);
        else
            $display("test %0d %s: %0d errors", t, name, errors - err_before);
    endtask

    initial begin
        int err_before;
        rst = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 11'd0;
        pwdata = 32'd0;
        for (int t = 0; t < NUM_RANDOM; t++) begin
            err_before = errors;
            gen_random_program();
            run_test(8'hd8);
            report_test(t, "random program", err_before);
        end
        err_before = errors;
        build_trap_program(1'b0, 12'h05a);
        run_test(8'hd0);
        check_word(dut_mem[8'hd0], 32'h0000_005a, "interrupt handler marker");
        check_word(dut_mem[8'hef], 32'd2, "interrupt stacked pc");
        report_test(NUM_RANDOM, "software interrupt", err_before);
        err_before = errors;
        build_trap_program(1'b1, 12'h03c);
        run_test(8'hd0);
        check_word(dut_mem[8'hd0], 32'h0000_003c, "exception handler marker");
        check_word(dut_mem[8'hef], 32'd2, "exception stacked pc");
        report_test(NUM_RANDOM + 1, "illegal opcode", err_before);
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+bench
hw/cpu_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/control_unit.sv
hw/shared_memory.sv
hw/cpu_top.sv
bench/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench, then look for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module cpu_tb -o cpu_tb_sim \
    > build.log 2>&1 \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
